//--- logic/store_defines.svh
`ifndef STORE_DEFINES_SVH
`define STORE_DEFINES_SVH

// ==================================================
// storage geometry
// ==================================================
`define BYTE_LEN_IN_BITS        8
`define ENTRY_WIDTH_IN_BITS     64
`define NUM_SET                 64
`define SET_ADDR_WIDTH_IN_BITS  ($clog2(`NUM_SET) + 1)  // spare bit flags out of range
`define WRITE_MASK_LEN          (`ENTRY_WIDTH_IN_BITS / `BYTE_LEN_IN_BITS)

// ==================================================
// flow control
// ==================================================
`define REQ_CREDITS             4   // decode buffer depth
`define RESP_CREDITS            4   // consumer slots
`define RESULT_DEPTH            4
`define ID_WIDTH                6

`endif

//--- logic/store_req_pkg.sv
`include "store_defines.svh"

package store_req_pkg;

    typedef enum logic [0:0]
    {
        op_read  = 1'b0,
        op_write = 1'b1
    } store_op_e;

    // request as seen on the external port
    typedef struct packed
    {
        logic [`ID_WIDTH - 1 : 0]                id;
        store_op_e                               op;
        logic [`SET_ADDR_WIDTH_IN_BITS - 1 : 0]  set_addr;
        logic [`WRITE_MASK_LEN - 1 : 0]          byte_mask;
        logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]     write_data;
    } store_req_t;

    // decoded access, decode to execute
    typedef struct packed
    {
        logic [`ID_WIDTH - 1 : 0]                id;
        logic                                    is_write;
        logic                                    range_error;
        logic [`WRITE_MASK_LEN - 1 : 0]          write_en;     // zero for reads
        logic [`SET_ADDR_WIDTH_IN_BITS - 1 : 0]  set_addr;
        logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]     write_data;
    } store_access_t;

endpackage

//--- logic/store_resp_pkg.sv
`include "store_defines.svh"

package store_resp_pkg;

    typedef enum logic [1:0]
    {
        resp_read_done   = 2'd0,
        resp_write_done  = 2'd1,
        resp_range_error = 2'd2
    } store_resp_kind_e;

    // writes return the old entry and old valid bit
    typedef struct packed
    {
        logic [`ID_WIDTH - 1 : 0]                id;
        store_resp_kind_e                        kind;
        logic                                    entry_valid;
        logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]     entry_data;
    } store_resp_t;

endpackage

//--- logic/single_port_blockram.sv
`timescale 1ns/100ps
`include "store_defines.svh"

module single_port_blockram
#(
    parameter with_valid_array = "Yes"
)
(
    input  logic                                    clk_in,
    input  logic                                    reset_in,

    input  logic                                    access_en,
    input  logic [`WRITE_MASK_LEN - 1 : 0]          write_en,
    input  logic [`SET_ADDR_WIDTH_IN_BITS - 1 : 0]  access_set_addr,

    input  logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]     write_entry,
    output logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]     read_entry,
    output logic                                    read_valid
);

    localparam int index_width = `SET_ADDR_WIDTH_IN_BITS - 1;

    logic [`ENTRY_WIDTH_IN_BITS - 1 : 0] blockram [`NUM_SET];
    logic [index_width - 1 : 0]          set_index;

    assign set_index = access_set_addr[index_width - 1 : 0];  // callers keep spare bit clear

    // ==================================================
    // valid bits
    // ==================================================
    generate
        if (with_valid_array == "Yes")
        begin : g_valid_array
            logic [`NUM_SET - 1 : 0] valid_array;

            always_ff @(posedge clk_in)
            begin
                if (reset_in)
                begin
                    valid_array <= '0;
                    read_valid  <= 1'b0;
                end
                else
                begin
                    if (access_en && (|write_en))
                    begin
                        valid_array[set_index] <= 1'b1;
                    end

                    // old valid bit, read before write
                    read_valid <= access_en ? valid_array[set_index] : 1'b0;
                end
            end
        end
        else
        begin : g_no_valid_array
            always_ff @(posedge clk_in)
            begin
                if (reset_in)
                    read_valid <= 1'b0;
                else
                    read_valid <= 1'b1;  // every set counts as valid
            end
        end
    endgenerate

    // ==================================================
    // byte-masked storage
    // ==================================================
    always_ff @(posedge clk_in)
    begin
        if (access_en)
        begin
            for (int lane = 0; lane < `WRITE_MASK_LEN; lane++)
            begin
                if (write_en[lane])
                begin
                    blockram[set_index][lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS]
                        <= write_entry[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
                end
            end

            read_entry <= blockram[set_index];  // old content
        end
    end

endmodule

//--- logic/store_request_decode.sv
`timescale 1ns/100ps
`include "store_defines.svh"

module store_request_decode
(
    input  logic                            clk_in,
    input  logic                            reset_in,

    input  logic                            req_valid,
    input  store_req_pkg::store_req_t       req,
    output logic                            req_credit,

    input  logic                            has_room,
    output logic                            issue,
    output store_req_pkg::store_access_t    access
);
    import store_req_pkg::*;

    localparam int ptr_width   = $clog2(`REQ_CREDITS);
    localparam int count_width = $clog2(`REQ_CREDITS + 1);

    store_req_t                 buffer [`REQ_CREDITS];
    logic [ptr_width - 1 : 0]   wr_ptr;
    logic [ptr_width - 1 : 0]   rd_ptr;
    logic [count_width - 1 : 0] count;
    store_req_t                 head;

    function automatic logic [ptr_width - 1 : 0] next_ptr
    (
        input logic [ptr_width - 1 : 0] ptr
    );
        return (ptr == ptr_width'(`REQ_CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ==================================================
    // credit buffer
    // ==================================================
    always_ff @(posedge clk_in)
    begin
        if (req_valid)
            buffer[wr_ptr] <= req;  // requester holds a credit
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (req_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (issue)
                rd_ptr <= next_ptr(rd_ptr);

            case ({req_valid, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign issue      = (count != '0) && has_room;
    assign req_credit = issue;  // slot frees as head leaves
    assign head       = buffer[rd_ptr];

    // ==================================================
    // decode
    // ==================================================
    always_comb
    begin
        access.id          = head.id;
        access.is_write    = (head.op == op_write);
        access.range_error = (head.set_addr >= `NUM_SET);
        access.write_en    = access.is_write ? head.byte_mask : '0;
        access.set_addr    = head.set_addr;
        access.write_data  = head.write_data;
    end

endmodule

//--- logic/store_execute.sv
`timescale 1ns/100ps
`include "store_defines.svh"

module store_execute
(
    input  logic                            clk_in,
    input  logic                            reset_in,

    input  logic                            issue,
    input  store_req_pkg::store_access_t    access,

    output logic                            result_valid,
    output store_resp_pkg::store_resp_t     result
);
    import store_resp_pkg::*;

    logic                                   ram_en;
    logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]    ram_entry;
    logic                                   ram_valid;

    logic [`ID_WIDTH - 1 : 0]               id_q;
    store_resp_kind_e                       kind_q;
    logic                                   error_q;

    assign ram_en = issue && !access.range_error;  // bad addresses never touch the ram

    single_port_blockram
    #(
        .with_valid_array   ("Yes")
    )
    u_blockram
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .access_en          (ram_en),
        .write_en           (access.write_en),
        .access_set_addr    (access.set_addr),
        .write_entry        (access.write_data),
        .read_entry         (ram_entry),
        .read_valid         (ram_valid)
    );

    // side register, lines up with the ram output
    always_ff @(posedge clk_in)
    begin
        id_q    <= access.id;
        error_q <= access.range_error;
        if (access.range_error)
            kind_q <= resp_range_error;
        else if (access.is_write)
            kind_q <= resp_write_done;
        else
            kind_q <= resp_read_done;
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
            result_valid <= 1'b0;
        else
            result_valid <= issue;
    end

    assign result.id          = id_q;
    assign result.kind        = kind_q;
    assign result.entry_valid = error_q ? 1'b0 : ram_valid;
    assign result.entry_data  = error_q ? '0 : ram_entry;

endmodule

//--- logic/store_result_queue.sv
`timescale 1ns/100ps
`include "store_defines.svh"

module store_result_queue
(
    input  logic                            clk_in,
    input  logic                            reset_in,

    input  logic                            issue,
    input  logic                            result_valid,
    input  store_resp_pkg::store_resp_t     result,
    output logic                            has_room,

    output logic                            resp_valid,
    output store_resp_pkg::store_resp_t     resp,
    input  logic                            resp_credit
);
    import store_resp_pkg::*;

    localparam int ptr_width    = $clog2(`RESULT_DEPTH);
    localparam int count_width  = $clog2(`RESULT_DEPTH + 1);
    localparam int credit_width = $clog2(`RESP_CREDITS + 1);

    store_resp_t                    queue [`RESULT_DEPTH];
    logic [ptr_width - 1 : 0]       wr_ptr;
    logic [ptr_width - 1 : 0]       rd_ptr;
    logic [count_width - 1 : 0]     count;
    logic [count_width - 1 : 0]     inflight;   // issued, not yet returned
    logic [count_width : 0]         occupancy;
    logic [credit_width - 1 : 0]    credits;

    function automatic logic [ptr_width - 1 : 0] next_ptr
    (
        input logic [ptr_width - 1 : 0] ptr
    );
        return (ptr == ptr_width'(`RESULT_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ==================================================
    // response fifo
    // ==================================================
    always_ff @(posedge clk_in)
    begin
        if (result_valid)
            queue[wr_ptr] <= result;
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            inflight <= '0;
            credits  <= credit_width'(`RESP_CREDITS);
        end
        else
        begin
            if (result_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (resp_valid)
                rd_ptr <= next_ptr(rd_ptr);

            count    <= count + count_width'(result_valid) - count_width'(resp_valid);
            inflight <= inflight + count_width'(issue) - count_width'(result_valid);
            credits  <= credits - credit_width'(resp_valid) + credit_width'(resp_credit);
        end
    end

    // ==================================================
    // outputs
    // ==================================================
    assign occupancy  = count + inflight;
    assign has_room   = (occupancy < `RESULT_DEPTH);
    assign resp_valid = (count != '0) && (credits != '0);  // needs a consumer slot
    assign resp       = queue[rd_ptr];

endmodule

//--- logic/store_top.sv
`timescale 1ns/100ps

module store_top
(
    input  logic                            clk_in,
    input  logic                            reset_in,

    input  logic                            req_valid,
    input  store_req_pkg::store_req_t       req,
    output logic                            req_credit,

    output logic                            resp_valid,
    output store_resp_pkg::store_resp_t     resp,
    input  logic                            resp_credit
);
    import store_req_pkg::*;
    import store_resp_pkg::*;

    logic           issue;
    store_access_t  access;
    logic           result_valid;
    store_resp_t    result;
    logic           has_room;

    store_request_decode u_decode
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .req_valid      (req_valid),
        .req            (req),
        .req_credit     (req_credit),
        .has_room       (has_room),
        .issue          (issue),
        .access         (access)
    );

    store_execute u_execute
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .issue          (issue),
        .access         (access),
        .result_valid   (result_valid),
        .result         (result)
    );

    store_result_queue u_result
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .issue          (issue),
        .result_valid   (result_valid),
        .result         (result),
        .has_room       (has_room),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .resp_credit    (resp_credit)
    );

endmodule

//--- tests/store_checks.svh
`ifndef STORE_CHECKS_SVH
`define STORE_CHECKS_SVH

typedef logic [`ENTRY_WIDTH_IN_BITS - 1 : 0] field_t;

task automatic compare_field(input string name, input field_t got, input field_t exp);
    if (got !== exp)
        abort_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
endtask

task automatic check_read
(
    input store_resp_pkg::store_resp_t  got,
    input store_resp_pkg::store_resp_t  exp,
    input field_t                       care
);
    compare_field("resp.id", field_t'(got.id), field_t'(exp.id));
    compare_field("resp.kind", field_t'(got.kind), field_t'(exp.kind));
    compare_field("resp.entry_valid", field_t'(got.entry_valid), field_t'(exp.entry_valid));
    if (exp.entry_valid)  // unwritten sets carry no data
        compare_field("resp.entry_data", got.entry_data & care, exp.entry_data & care);
endtask

// old entry and old valid bit
task automatic check_write
(
    input store_resp_pkg::store_resp_t  got,
    input store_resp_pkg::store_resp_t  exp,
    input field_t                       care
);
    compare_field("resp.id", field_t'(got.id), field_t'(exp.id));
    compare_field("resp.kind", field_t'(got.kind), field_t'(exp.kind));
    compare_field("resp.entry_valid", field_t'(got.entry_valid), field_t'(exp.entry_valid));
    if (exp.entry_valid)
        compare_field("resp.entry_data", got.entry_data & care, exp.entry_data & care);
endtask

task automatic check_error(input store_resp_pkg::store_resp_t got,
                           input store_resp_pkg::store_resp_t exp);
    compare_field("resp.id", field_t'(got.id), field_t'(exp.id));
    compare_field("resp.kind", field_t'(got.kind), field_t'(exp.kind));
    compare_field("resp.entry_valid", field_t'(got.entry_valid), field_t'(1'b0));
    compare_field("resp.entry_data", got.entry_data, '0);
endtask

`endif

//--- tests/store_tb.sv
`timescale 1ns/100ps
`include "store_defines.svh"

module store_tb;
    import store_req_pkg::*;
    import store_resp_pkg::*;

    localparam int num_requests   = 400;
    localparam int timeout_cycles = num_requests * 40;
    localparam int starve_start   = 300;  // consumer holds its credits back
    localparam int starve_end     = 500;

    logic           clk_in      = 1'b0;
    logic           reset_in    = 1'b1;
    logic           req_valid   = 1'b0;
    store_req_t     req         = '0;
    logic           req_credit;
    logic           resp_valid;
    store_resp_t    resp;
    logic           resp_credit = 1'b0;

    logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]  model_data  [`NUM_SET];
    logic [`WRITE_MASK_LEN - 1 : 0]       model_known [`NUM_SET];  // bytes written so far
    logic                                 model_valid [`NUM_SET];
    store_resp_t                          exp_q  [$];
    logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]  care_q [$];

    int received    = 0;
    int cycle_count = 0;
    int free_slots;
    int pending_credits;
    int credit_delay;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    `include "store_checks.svh"

    always #20 clk_in = ~clk_in;

    store_top u_store_top
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .req_valid      (req_valid),
        .req            (req),
        .req_credit     (req_credit),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .resp_credit    (resp_credit)
    );

    always @(posedge clk_in)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
            abort_run("run timed out before all responses arrived");
    end

    // ==================================================
    // request generation and model
    // ==================================================
    task automatic make_request(input int n, output store_req_t r);
        store_resp_t                          exp;
        logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]  care;
        logic [31:0]                          rnd;
        int                                   pick;
        int                                   a;

        pick = $urandom_range(0, 99);
        if (pick < 8)
            a = $urandom_range(`NUM_SET, 2 * `NUM_SET - 1);  // out of range
        else if (pick < 20)
            a = $urandom_range(0, `NUM_SET - 1);
        else
            a = $urandom_range(0, 15);  // heavy reuse
        rnd          = $urandom;
        r.id         = n[`ID_WIDTH - 1 : 0];
        r.op         = ($urandom_range(0, 1) == 1) ? op_write : op_read;
        r.set_addr   = a[`SET_ADDR_WIDTH_IN_BITS - 1 : 0];
        r.byte_mask  = (rnd[`WRITE_MASK_LEN - 1 : 0] == '0) ? 1 : rnd[`WRITE_MASK_LEN - 1 : 0];
        r.write_data = {$urandom, $urandom};

        exp.id = r.id;
        care   = '0;
        if (a >= `NUM_SET)
        begin
            exp.kind        = resp_range_error;
            exp.entry_valid = 1'b0;
            exp.entry_data  = '0;
        end
        else
        begin
            exp.kind        = (r.op == op_write) ? resp_write_done : resp_read_done;
            exp.entry_valid = model_valid[a];
            exp.entry_data  = model_data[a];
            for (int b = 0; b < `WRITE_MASK_LEN; b++)
            begin
                if (model_known[a][b])
                    care[b * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS] = '1;
                if (r.op == op_write && r.byte_mask[b])
                    model_data[a][b * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS] =
                        r.write_data[b * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
            end
            if (r.op == op_write)
            begin
                model_known[a] = model_known[a] | r.byte_mask;
                model_valid[a] = 1'b1;
            end
        end
        exp_q.push_back(exp);
        care_q.push_back(care);
    endtask

    initial
    begin
        int          req_credits;
        int          sent;
        store_req_t  next_req;

        void'($urandom(28288));
        req_credits = `REQ_CREDITS;
        sent        = 0;
        for (int s = 0; s < `NUM_SET; s++)
        begin
            model_data[s]  = '0;
            model_known[s] = '0;
            model_valid[s] = 1'b0;
        end
        repeat (2) @(posedge clk_in);
        reset_in <= 1'b0;

        while (received < num_requests)
        begin
            @(posedge clk_in);
            req_valid <= 1'b0;
            if (req_credit)
                req_credits++;
            if (req_credits > `REQ_CREDITS)
                abort_run("request credits returned beyond the decode buffer depth");
            if (sent < num_requests && req_credits > 0 && $urandom_range(0, 3) != 0)
            begin
                make_request(sent, next_req);
                req_valid <= 1'b1;
                req       <= next_req;
                req_credits--;
                sent++;
            end
        end
        repeat (20) @(posedge clk_in);  // late duplicates show up here

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // ==================================================
    // consumer
    // ==================================================
    always @(posedge clk_in)
    begin
        store_resp_t                          exp;
        logic [`ENTRY_WIDTH_IN_BITS - 1 : 0]  care;

        if (reset_in)
        begin
            free_slots      = `RESP_CREDITS;
            pending_credits = 0;
            credit_delay    = 0;
            resp_credit    <= 1'b0;
        end
        else
        begin
            resp_credit <= 1'b0;
            if (resp_valid)
            begin
                if (free_slots == 0)
                    abort_run("response presented with no free consumer slot");
                if (exp_q.size() == 0)
                    abort_run("response arrived with no request outstanding");
                exp  = exp_q.pop_front();
                care = care_q.pop_front();
                case (exp.kind)
                    resp_read_done:  check_read(resp, exp, care);
                    resp_write_done: check_write(resp, exp, care);
                    default:         check_error(resp, exp);
                endcase
                free_slots--;
                pending_credits++;
                received <= received + 1;
            end
            if (pending_credits > 0 && (cycle_count < starve_start || cycle_count >= starve_end))
            begin
                if (credit_delay == 0)
                begin
                    resp_credit <= 1'b1;
                    pending_credits--;
                    free_slots++;
                    credit_delay = $urandom_range(0, 6);
                end
                else
                    credit_delay--;
            end
        end
    end

endmodule

//--- sources.f
+incdir+logic
+incdir+tests
logic/store_req_pkg.sv
logic/store_resp_pkg.sv
logic/single_port_blockram.sv
logic/store_request_decode.sv
logic/store_execute.sv
logic/store_result_queue.sv
logic/store_top.sv
tests/store_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := store_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
